/* xt_chipset.f */
design/xt_pkg.sv
design/bus_cycle_ctrl.sv
design/chipset_regs.sv
design/refresh_gen.sv
design/ems_mapper.sv
design/xt_ram.sv
design/xt_chipset.sv
tests/clock_gen.sv
tests/xt_chipset_sva.sv
tests/xt_chipset_tb.sv

/* tests/xt_chipset_tb.sv */
`timescale 1ns/1ns

module xt_chipset_tb;

    localparam xt_pkg::io_addr_t CFG_IO_BASE   = 10'h260;
    localparam xt_pkg::data_t    DIVISOR_RESET = 8'd18;
    localparam int               RAM_BYTES     = 131072;
    localparam int               WAIT_LIMIT    = 200;

    logic                clock;
    logic                reset;
    xt_pkg::addr_t       cpu_address;
    xt_pkg::data_t       cpu_write_data;
    xt_pkg::bus_status_t processor_status;
    logic                processor_ready;
    xt_pkg::data_t       cpu_read_data;
    logic                io_read_n;
    logic                io_write_n;
    logic                memory_read_n;
    logic                memory_write_n;
    logic                refresh_ack_n;
    logic                timer_out;

    // Reference model
    xt_pkg::data_t model_ram [0:RAM_BYTES-1];
    bit            model_valid [0:RAM_BYTES-1];
    xt_pkg::data_t model_regs [0:5];
    xt_pkg::addr_t written_low [$];
    int            ack_low_count = 0;
    int            refresh_pulses = 0;

    clock_gen clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    xt_chipset #(
        .CFG_IO_BASE           (CFG_IO_BASE),
        .RAM_ADDR_W            (17),
        .REFRESH_DIVISOR_RESET (DIVISOR_RESET)
    ) xt_chipset_inst (
        .clock            (clock),
        .reset            (reset),
        .cpu_address      (cpu_address),
        .cpu_write_data   (cpu_write_data),
        .processor_status (processor_status),
        .processor_ready  (processor_ready),
        .cpu_read_data    (cpu_read_data),
        .io_read_n        (io_read_n),
        .io_write_n       (io_write_n),
        .memory_read_n    (memory_read_n),
        .memory_write_n   (memory_write_n),
        .refresh_ack_n    (refresh_ack_n),
        .timer_out        (timer_out)
    );

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped after the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    function automatic xt_pkg::io_addr_t reg_port(input int offset);
        return CFG_IO_BASE + 10'(offset);
    endfunction

    function automatic xt_pkg::data_t model_io_read(input xt_pkg::io_addr_t port);
        int offset;
        offset = int'(port) - int'(CFG_IO_BASE);
        if (offset >= 0 && offset <= 5)
            return model_regs[offset];
        return 8'hFF;
    endfunction

    // RAM byte index for a CPU address or -1 on a miss
    function automatic int model_index(input xt_pkg::addr_t address);
        int window_offset;
        int page;
        if (address < 20'h10000)
            return int'(address);
        if (address < xt_pkg::EMS_WINDOW_BASE || address >= xt_pkg::EMS_WINDOW_BASE + 20'h10000)
            return -1;
        window_offset = int'(address - xt_pkg::EMS_WINDOW_BASE);
        page = window_offset / 16384;
        if (!model_regs[page][7])
            return -1;
        return 65536 + (model_regs[page] % 4) * 16384 + window_offset % 16384;
    endfunction

    function automatic logic strobe_low(input xt_pkg::bus_status_t status);
        case (status)
            xt_pkg::STATUS_IO_READ:   return !io_read_n;
            xt_pkg::STATUS_IO_WRITE:  return !io_write_n;
            xt_pkg::STATUS_MEM_READ:  return !memory_read_n;
            xt_pkg::STATUS_MEM_WRITE: return !memory_write_n;
            default:                  return 1'b0;
        endcase
    endfunction

    // Latency counts clocks from the strobe edge to processor_ready
    task automatic run_cycle(input xt_pkg::bus_status_t status, input xt_pkg::addr_t address,
                             input xt_pkg::data_t wdata, output xt_pkg::data_t rdata,
                             output int latency);
        int clocks;
        int start;
        clocks = 0;
        start = -1;
        cpu_address = address;
        cpu_write_data = wdata;
        processor_status = status;
        do
        begin
            @(negedge clock);
            clocks++;
            if (start < 0 && strobe_low(status))
                start = clocks;
            if (clocks > WAIT_LIMIT)
            begin
                $display("Bus cycle with status %0d got no processor_ready in %0d clocks",
                         status, WAIT_LIMIT);
                abort_run();
            end
        end while (!processor_ready);
        if (start < 0)
        begin
            $display("processor_ready came without the command strobe of status %0d", status);
            abort_run();
        end
        rdata = cpu_read_data;
        latency = clocks - start;
        processor_status = xt_pkg::STATUS_PASSIVE;
        @(negedge clock);
    endtask

    task automatic io_write(input xt_pkg::io_addr_t port, input xt_pkg::data_t data);
        xt_pkg::data_t unused_data;
        int            latency;
        int            offset;
        run_cycle(xt_pkg::STATUS_IO_WRITE, {10'($urandom), port}, data, unused_data, latency);
        check_value("I/O write latency", latency, 2);
        offset = int'(port) - int'(CFG_IO_BASE);
        if (offset >= 0 && offset <= 5)
            model_regs[offset] = (offset == 4) ? (data & 8'h0F) : data;
    endtask

    task automatic io_read_check(input xt_pkg::io_addr_t port);
        xt_pkg::data_t rdata;
        int            latency;
        run_cycle(xt_pkg::STATUS_IO_READ, {10'($urandom), port}, 8'($urandom), rdata, latency);
        check_value("I/O read latency", latency, 2);
        check_value("cpu_read_data", rdata, model_io_read(port));
    endtask

    task automatic mem_write(input xt_pkg::addr_t address, input xt_pkg::data_t data);
        xt_pkg::data_t unused_data;
        int            latency;
        int            index;
        run_cycle(xt_pkg::STATUS_MEM_WRITE, address, data, unused_data, latency);
        check_value("memory write latency", latency, model_regs[4][3:2] + 2);
        index = model_index(address);
        if (index >= 0)
        begin
            model_ram[index] = data;
            model_valid[index] = 1'b1;
        end
    endtask

    task automatic mem_read_check(input xt_pkg::addr_t address);
        xt_pkg::data_t rdata;
        xt_pkg::data_t expected;
        int            latency;
        int            index;
        index = model_index(address);
        // Give untouched bytes a known value first
        if (index >= 0 && !model_valid[index])
            mem_write(address, 8'($urandom));
        expected = (index >= 0) ? model_ram[index] : 8'hFF;
        run_cycle(xt_pkg::STATUS_MEM_READ, address, 8'($urandom), rdata, latency);
        check_value("memory read latency", latency, model_regs[4][1:0] + 2);
        check_value("cpu_read_data", rdata, expected);
    endtask

    // Clocks between two timer_out toggles with the current divisor
    task automatic check_timer_half_period();
        logic last_level;
        int   clocks;
        int   toggles;
        int   gap;
        last_level = timer_out;
        clocks = 0;
        toggles = 0;
        gap = 0;
        while (toggles < 2)
        begin
            @(negedge clock);
            clocks++;
            gap++;
            if (timer_out !== last_level)
            begin
                toggles++;
                last_level = timer_out;
                if (toggles == 1)
                    gap = 0;
            end
            if (clocks > 4 * WAIT_LIMIT)
            begin
                $display("timer_out stopped toggling with divisor %0d", model_regs[5]);
                abort_run();
            end
        end
        check_value("timer_out half period", gap, model_regs[5] + 1);
    endtask

    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (!refresh_ack_n)
                ack_low_count++;
            else if (ack_low_count != 0)
            begin
                check_value("refresh_ack_n low cycles", ack_low_count, xt_pkg::REFRESH_CYCLES);
                refresh_pulses++;
                ack_low_count = 0;
            end
        end
    end

    // Stop at the first bus protocol assertion failure
    always @(negedge clock)
    begin
        if (xt_chipset_inst.u_bus_cycle_ctrl.sva_inst.failure_count != 0)
        begin
            $display("Error at %0t ns: a bus protocol assertion failed", $time);
            abort_run();
        end
    end

    initial
    begin
        xt_pkg::io_addr_t port;
        xt_pkg::addr_t    address;
        xt_pkg::data_t    data;
        logic [13:0]      window_offset;
        int               waited;
        int               pulses_before;
        void'($urandom(32'h62f1));
        cpu_address = '0;
        cpu_write_data = '0;
        processor_status = xt_pkg::STATUS_PASSIVE;
        model_regs = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, DIVISOR_RESET};
        waited = 0;
        do
        begin
            @(negedge clock);
            waited++;
            if (waited > 20)
            begin
                $display("Reset was never released");
                abort_run();
            end
        end while (reset);

        // Reset values and then random register traffic
        for (int i = 0; i < 6; i++)
            io_read_check(reg_port(i));
        check_timer_half_period();
        for (int i = 0; i < 40; i++)
        begin
            port = reg_port($urandom_range(5));
            io_write(port, 8'($urandom));
            if (port == reg_port(xt_pkg::REG_REFRESH))
                check_timer_half_period();
            io_read_check(port);
            io_read_check(10'($urandom));
        end

        // Low 64 KB and unmapped space
        for (int i = 0; i < 60; i++)
        begin
            address = 20'($urandom_range(20'hFFFF));
            mem_write(address, 8'($urandom));
            written_low.push_back(address);
        end
        for (int i = 0; i < 60; i++)
        begin
            if ($urandom_range(3) != 0)
                address = written_low[$urandom_range(written_low.size() - 1)];
            else
                address = 20'h10000 + 20'($urandom_range(20'hBFFFF));
            mem_read_check(address);
        end

        // Pages 0 and 1 share RAM page 2 and page 3 stays disabled
        io_write(reg_port(0), 8'h92);
        io_write(reg_port(1), 8'hC6);
        io_write(reg_port(2), 8'h81);
        io_write(reg_port(3), 8'h03);
        for (int i = 0; i < 30; i++)
        begin
            window_offset = 14'($urandom);
            data = 8'($urandom);
            mem_write(xt_pkg::EMS_WINDOW_BASE + 20'(window_offset), data);
            mem_read_check(xt_pkg::EMS_WINDOW_BASE + 20'h4000 + 20'(window_offset));
            mem_read_check(xt_pkg::EMS_WINDOW_BASE + 20'hC000 + 20'(window_offset));
            mem_read_check(xt_pkg::EMS_WINDOW_BASE + 20'($urandom_range(20'hBFFF)));
        end
        for (int i = 0; i < 20; i++)
        begin
            io_write(reg_port($urandom_range(3)), 8'($urandom));
            address = xt_pkg::EMS_WINDOW_BASE + 20'($urandom_range(20'hFFFF));
            mem_write(address, 8'($urandom));
            mem_read_check(address);
        end

        // Every read and write wait count
        for (int rw = 0; rw < 4; rw++)
        begin
            for (int ww = 0; ww < 4; ww++)
            begin
                io_write(reg_port(xt_pkg::REG_WAIT), 8'(ww * 4 + rw));
                address = 20'($urandom_range(20'hFFFF));
                mem_write(address, 8'($urandom));
                mem_read_check(address);
            end
        end

        // Dense refresh
        io_write(reg_port(xt_pkg::REG_REFRESH), 8'd1);
        check_timer_half_period();
        pulses_before = refresh_pulses;
        for (int i = 0; i < 40; i++)
        begin
            case ($urandom_range(2))
                0:
                    io_read_check(reg_port($urandom_range(5)));
                1:
                    mem_write(20'($urandom_range(20'hFFFF)), 8'($urandom));
                default:
                    mem_read_check(written_low[$urandom_range(written_low.size() - 1)]);
            endcase
        end
        check_value("refresh pulses under small divisor", refresh_pulses > pulses_before, 1);

        if (xt_chipset_inst.u_bus_cycle_ctrl.sva_inst.failure_count != 0)
        begin
            $display("Bus protocol assertions failed %0d times",
                     xt_chipset_inst.u_bus_cycle_ctrl.sva_inst.failure_count);
            abort_run();
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* tests/xt_chipset_sva.sv */
`timescale 1ns/1ns

module xt_chipset_sva (
    input logic clock,
    input logic reset,
    input logic io_read_n,
    input logic io_write_n,
    input logic memory_read_n,
    input logic memory_write_n,
    input logic refresh_ack_n,
    input logic processor_ready
);

    int         failure_count = 0;
    logic [3:0] strobe_active;

    assign strobe_active = {!io_read_n, !io_write_n, !memory_read_n, !memory_write_n};

    // DACK0 owns the bus
    no_strobe_in_refresh: assert property (@(posedge clock) disable iff (reset)
        !refresh_ack_n |-> (strobe_active == 4'b0000))
    else
    begin
        $error("command strobe active while refresh_ack_n is low");
        failure_count++;
    end

    single_strobe: assert property (@(posedge clock) disable iff (reset)
        $onehot0(strobe_active))
    else
    begin
        $error("more than one command strobe active");
        failure_count++;
    end

    ready_one_clock: assert property (@(posedge clock) disable iff (reset)
        processor_ready |=> !processor_ready)
    else
    begin
        $error("processor_ready held longer than one clock");
        failure_count++;
    end

    refresh_length: assert property (@(posedge clock) disable iff (reset)
        $fell(refresh_ack_n) |-> (!refresh_ack_n)[*xt_pkg::REFRESH_CYCLES] ##1 refresh_ack_n)
    else
    begin
        $error("refresh_ack_n pulse has the wrong length");
        failure_count++;
    end

endmodule

bind bus_cycle_ctrl xt_chipset_sva sva_inst (
    .clock           (clock),
    .reset           (reset),
    .io_read_n       (io_read_n),
    .io_write_n      (io_write_n),
    .memory_read_n   (memory_read_n),
    .memory_write_n  (memory_write_n),
    .refresh_ack_n   (refresh_ack_n),
    .processor_ready (processor_ready)
);

/* tests/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
    parameter int HALF_PERIOD = 10
) (
    output logic clock,
    output logic reset
);

    initial
    begin
        clock = 1'b0;
        forever
            #HALF_PERIOD clock = !clock;
    end

    // Held over two rising edges, released between edges
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

/* design/xt_chipset.sv */
`timescale 1ns/1ns

module xt_chipset #(
    parameter xt_pkg::io_addr_t CFG_IO_BASE           = 10'h260,
    parameter int               RAM_ADDR_W            = 17,
    parameter xt_pkg::data_t    REFRESH_DIVISOR_RESET = 8'd18
) (
    input  logic                clock,
    input  logic                reset,
    input  xt_pkg::addr_t       cpu_address,
    input  xt_pkg::data_t       cpu_write_data,
    input  xt_pkg::bus_status_t processor_status,
    output logic                processor_ready,
    output xt_pkg::data_t       cpu_read_data,
    output logic                io_read_n,
    output logic                io_write_n,
    output logic                memory_read_n,
    output logic                memory_write_n,
    output logic                refresh_ack_n,
    output logic                timer_out
);

    logic                  refresh_request;
    logic                  memory_access_ready;
    logic                  reg_hit;
    logic                  ram_hit;
    xt_pkg::data_t         reg_read_data;
    xt_pkg::data_t         ram_read_data;
    xt_pkg::ems_page_t     ems_page [0:3];
    xt_pkg::wait_t         read_wait;
    xt_pkg::wait_t         write_wait;
    xt_pkg::data_t         refresh_divisor;
    logic [RAM_ADDR_W-1:0] ram_address;

    bus_cycle_ctrl u_bus_cycle_ctrl (
        .clock               (clock),
        .reset               (reset),
        .processor_status    (processor_status),
        .refresh_request     (refresh_request),
        .memory_access_ready (memory_access_ready),
        .reg_hit             (reg_hit),
        .ram_hit             (ram_hit),
        .reg_read_data       (reg_read_data),
        .ram_read_data       (ram_read_data),
        .io_read_n           (io_read_n),
        .io_write_n          (io_write_n),
        .memory_read_n       (memory_read_n),
        .memory_write_n      (memory_write_n),
        .refresh_ack_n       (refresh_ack_n),
        .processor_ready     (processor_ready),
        .cpu_read_data       (cpu_read_data)
    );

    // I/O space decodes only the low 10 address bits
    chipset_regs #(
        .CFG_IO_BASE           (CFG_IO_BASE),
        .REFRESH_DIVISOR_RESET (REFRESH_DIVISOR_RESET)
    ) u_chipset_regs (
        .clock           (clock),
        .reset           (reset),
        .io_read_n       (io_read_n),
        .io_write_n      (io_write_n),
        .io_address      (cpu_address[9:0]),
        .write_data      (cpu_write_data),
        .ems_page        (ems_page),
        .read_wait       (read_wait),
        .write_wait      (write_wait),
        .refresh_divisor (refresh_divisor),
        .reg_read_data   (reg_read_data),
        .reg_hit         (reg_hit)
    );

    refresh_gen u_refresh_gen (
        .clock           (clock),
        .reset           (reset),
        .refresh_divisor (refresh_divisor),
        .refresh_ack_n   (refresh_ack_n),
        .refresh_request (refresh_request),
        .timer_out       (timer_out)
    );

    ems_mapper #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ems_mapper (
        .cpu_address (cpu_address),
        .ems_page    (ems_page),
        .ram_address (ram_address),
        .ram_hit     (ram_hit)
    );

    xt_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_xt_ram (
        .clock               (clock),
        .reset               (reset),
        .memory_read_n       (memory_read_n),
        .memory_write_n      (memory_write_n),
        .ram_hit             (ram_hit),
        .ram_address         (ram_address),
        .write_data          (cpu_write_data),
        .read_wait           (read_wait),
        .write_wait          (write_wait),
        .ram_read_data       (ram_read_data),
        .memory_access_ready (memory_access_ready)
    );

endmodule

/* design/xt_ram.sv */
`timescale 1ns/1ns

module xt_ram #(
    parameter int RAM_ADDR_W = 17
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  memory_read_n,
    input  logic                  memory_write_n,
    input  logic                  ram_hit,
    input  logic [RAM_ADDR_W-1:0] ram_address,
    input  xt_pkg::data_t         write_data,
    input  xt_pkg::wait_t         read_wait,
    input  xt_pkg::wait_t         write_wait,
    output xt_pkg::data_t         ram_read_data,
    output logic                  memory_access_ready
);

    localparam int RAM_BYTES = 2 ** RAM_ADDR_W;

    xt_pkg::data_t memory_array [RAM_BYTES];
    logic [2:0]    wait_count;
    logic          access_active;
    xt_pkg::wait_t wait_target;

    assign access_active = !memory_read_n || !memory_write_n;
    assign wait_target   = memory_write_n ? read_wait : write_wait;

    // Counts clocks since the strobe fell, misses included
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            wait_count          <= '0;
            memory_access_ready <= 1'b0;
        end
        else if (!access_active)
        begin
            wait_count          <= '0;
            memory_access_ready <= 1'b0;
        end
        else
        begin
            wait_count          <= wait_count + 3'd1;
            memory_access_ready <= (wait_count == {1'b0, wait_target});
        end
    end

    always_ff @(posedge clock)
    begin
        if (!memory_write_n && ram_hit && (wait_count == '0))
            memory_array[ram_address] <= write_data;
        ram_read_data <= memory_array[ram_address];
    end

endmodule

/* design/ems_mapper.sv */
`timescale 1ns/1ns

module ems_mapper #(
    parameter int RAM_ADDR_W = 17
) (
    input  xt_pkg::addr_t           cpu_address,
    input  xt_pkg::ems_page_t       ems_page [0:3],
    output logic [RAM_ADDR_W-1:0]   ram_address,
    output logic                    ram_hit
);

    xt_pkg::ems_page_t selected_page;
    logic              in_low_ram;
    logic              in_window;

    assign selected_page = ems_page[cpu_address[15:14]];
    assign in_low_ram    = (cpu_address[19:16] == 4'h0);
    assign in_window     = (cpu_address[19:16] == xt_pkg::EMS_WINDOW_BASE[19:16]);

    always_comb
    begin
        ram_address = RAM_ADDR_W'(cpu_address[15:0]);
        ram_hit     = 1'b0;
        if (in_low_ram)
        begin
            ram_hit = 1'b1;
        end
        else if (in_window && selected_page[7])
        begin
            // Pages live above the first 64 KB
            ram_address = RAM_ADDR_W'({1'b1, selected_page[1:0], cpu_address[13:0]});
            ram_hit     = 1'b1;
        end
    end

endmodule

/* design/refresh_gen.sv */
`timescale 1ns/1ns

module refresh_gen (
    input  logic          clock,
    input  logic          reset,
    input  xt_pkg::data_t refresh_divisor,
    input  logic          refresh_ack_n,
    output logic          refresh_request,
    output logic          timer_out
);

    xt_pkg::data_t divide_count;
    logic          prev_timer_out;
    logic          timer_rise;

    assign timer_rise = timer_out && !prev_timer_out;

    // Square wave with one half period per reload
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            divide_count <= '0;
            timer_out    <= 1'b0;
        end
        else if (divide_count == '0)
        begin
            divide_count <= refresh_divisor;
            timer_out    <= !timer_out;
        end
        else
        begin
            divide_count <= divide_count - 8'd1;
        end
    end

    // DRQ0 latch
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            prev_timer_out  <= 1'b0;
            refresh_request <= 1'b0;
        end
        else
        begin
            prev_timer_out <= timer_out;
            if (!refresh_ack_n)
                refresh_request <= 1'b0;
            else if (timer_rise)
                refresh_request <= 1'b1;
        end
    end

endmodule

/* design/chipset_regs.sv */
`timescale 1ns/1ns

module chipset_regs #(
    parameter xt_pkg::io_addr_t CFG_IO_BASE           = 10'h260,
    parameter xt_pkg::data_t    REFRESH_DIVISOR_RESET = 8'd18
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              io_read_n,
    input  logic              io_write_n,
    input  xt_pkg::io_addr_t  io_address,
    input  xt_pkg::data_t     write_data,
    output xt_pkg::ems_page_t ems_page [0:3],
    output xt_pkg::wait_t     read_wait,
    output xt_pkg::wait_t     write_wait,
    output xt_pkg::data_t     refresh_divisor,
    output xt_pkg::data_t     reg_read_data,
    output logic              reg_hit
);

    xt_pkg::io_addr_t port_offset;
    logic             port_match;
    logic             prev_io_write_n;
    logic             write_strobe;

    assign port_offset = io_address - CFG_IO_BASE;
    assign port_match  = (port_offset <= 10'(xt_pkg::REG_REFRESH));

    // Write once, on the first clock of the strobe
    assign write_strobe = port_match && !io_write_n && prev_io_write_n;
    assign reg_hit      = port_match && !io_read_n;

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            prev_io_write_n <= 1'b1;
            for (int i = 0; i < 4; i++)
                ems_page[i] <= '0;
            read_wait       <= '0;
            write_wait      <= '0;
            refresh_divisor <= REFRESH_DIVISOR_RESET;
        end
        else
        begin
            prev_io_write_n <= io_write_n;
            if (write_strobe)
            begin
                case (port_offset[2:0])
                    xt_pkg::REG_EMS0, xt_pkg::REG_EMS1, xt_pkg::REG_EMS2, xt_pkg::REG_EMS3:
                        ems_page[port_offset[1:0]] <= write_data;
                    xt_pkg::REG_WAIT:
                    begin
                        read_wait  <= write_data[1:0];
                        write_wait <= write_data[3:2];
                    end
                    xt_pkg::REG_REFRESH:
                        refresh_divisor <= write_data;
                    default:
                        refresh_divisor <= refresh_divisor;
                endcase
            end
        end
    end

    always_comb
    begin
        reg_read_data = 8'hFF;
        if (reg_hit)
        begin
            case (port_offset[2:0])
                xt_pkg::REG_EMS0, xt_pkg::REG_EMS1, xt_pkg::REG_EMS2, xt_pkg::REG_EMS3:
                    reg_read_data = ems_page[port_offset[1:0]];
                xt_pkg::REG_WAIT:
                    reg_read_data = {4'h0, write_wait, read_wait};
                xt_pkg::REG_REFRESH:
                    reg_read_data = refresh_divisor;
                default:
                    reg_read_data = 8'hFF;
            endcase
        end
    end

endmodule

/* design/bus_cycle_ctrl.sv */
`timescale 1ns/1ns

module bus_cycle_ctrl (
    input  logic                clock,
    input  logic                reset,
    input  xt_pkg::bus_status_t processor_status,
    input  logic                refresh_request,
    input  logic                memory_access_ready,
    input  logic                reg_hit,
    input  logic                ram_hit,
    input  xt_pkg::data_t       reg_read_data,
    input  xt_pkg::data_t       ram_read_data,
    output logic                io_read_n,
    output logic                io_write_n,
    output logic                memory_read_n,
    output logic                memory_write_n,
    output logic                refresh_ack_n,
    output logic                processor_ready,
    output xt_pkg::data_t       cpu_read_data
);

    localparam logic [2:0] REFRESH_LAST = 3'(xt_pkg::REFRESH_CYCLES - 1);

    xt_pkg::cycle_state_t state;
    logic [2:0]           cycle_count;
    logic                 finish;

    // Last clock of an active command
    assign finish = ((state == xt_pkg::IO_CMD) && (cycle_count == 3'd1))
                  || ((state == xt_pkg::MEM_CMD) && memory_access_ready);

    assign processor_ready = (state == xt_pkg::DONE);

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            state          <= xt_pkg::IDLE;
            cycle_count    <= '0;
            io_read_n      <= 1'b1;
            io_write_n     <= 1'b1;
            memory_read_n  <= 1'b1;
            memory_write_n <= 1'b1;
            refresh_ack_n  <= 1'b1;
        end
        else
        begin
            case (state)
                xt_pkg::IDLE:
                begin
                    cycle_count <= '0;
                    // Refresh steals the slot ahead of the CPU
                    if (refresh_request)
                    begin
                        refresh_ack_n <= 1'b0;
                        state         <= xt_pkg::REFRESH;
                    end
                    else
                    begin
                        case (processor_status)
                            xt_pkg::STATUS_IO_READ:
                            begin
                                io_read_n <= 1'b0;
                                state     <= xt_pkg::IO_CMD;
                            end
                            xt_pkg::STATUS_IO_WRITE:
                            begin
                                io_write_n <= 1'b0;
                                state      <= xt_pkg::IO_CMD;
                            end
                            xt_pkg::STATUS_MEM_READ:
                            begin
                                memory_read_n <= 1'b0;
                                state         <= xt_pkg::MEM_CMD;
                            end
                            xt_pkg::STATUS_MEM_WRITE:
                            begin
                                memory_write_n <= 1'b0;
                                state          <= xt_pkg::MEM_CMD;
                            end
                            default:
                                state <= xt_pkg::IDLE;
                        endcase
                    end
                end
                xt_pkg::IO_CMD:
                begin
                    cycle_count <= cycle_count + 3'd1;
                    if (finish)
                    begin
                        io_read_n  <= 1'b1;
                        io_write_n <= 1'b1;
                        state      <= xt_pkg::DONE;
                    end
                end
                xt_pkg::MEM_CMD:
                begin
                    if (finish)
                    begin
                        memory_read_n  <= 1'b1;
                        memory_write_n <= 1'b1;
                        state          <= xt_pkg::DONE;
                    end
                end
                xt_pkg::REFRESH:
                begin
                    cycle_count <= cycle_count + 3'd1;
                    if (cycle_count == REFRESH_LAST)
                    begin
                        refresh_ack_n <= 1'b1;
                        state         <= xt_pkg::IDLE;
                    end
                end
                default:
                    state <= xt_pkg::IDLE;
            endcase
        end
    end

    // Open bus reads as FFh
    always_ff @(posedge clock)
    begin
        if (finish)
        begin
            if (!io_read_n)
                cpu_read_data <= reg_hit ? reg_read_data : 8'hFF;
            else if (!memory_read_n)
                cpu_read_data <= ram_hit ? ram_read_data : 8'hFF;
            else
                cpu_read_data <= 8'hFF;
        end
    end

endmodule

/* design/xt_pkg.sv */
package xt_pkg;

    // Bus widths
    typedef logic [19:0] addr_t;
    typedef logic [9:0]  io_addr_t;
    typedef logic [7:0]  data_t;

    // 8088 S2..S0 status
    typedef logic [2:0]  bus_status_t;

    localparam bus_status_t STATUS_IO_READ   = 3'd1;
    localparam bus_status_t STATUS_IO_WRITE  = 3'd2;
    localparam bus_status_t STATUS_MEM_READ  = 3'd5;
    localparam bus_status_t STATUS_MEM_WRITE = 3'd6;
    localparam bus_status_t STATUS_PASSIVE   = 3'd7;

    typedef logic [1:0]  wait_t;

    // Bit 7 enables the page, bits 6..0 hold the page number
    typedef logic [7:0]  ems_page_t;

    typedef enum logic [2:0]
    {
        IDLE,
        IO_CMD,
        MEM_CMD,
        REFRESH,
        DONE
    } cycle_state_t;

    // Offsets from the configuration port base
    localparam logic [2:0] REG_EMS0    = 3'd0;
    localparam logic [2:0] REG_EMS1    = 3'd1;
    localparam logic [2:0] REG_EMS2    = 3'd2;
    localparam logic [2:0] REG_EMS3    = 3'd3;
    localparam logic [2:0] REG_WAIT    = 3'd4;
    localparam logic [2:0] REG_REFRESH = 3'd5;

    // Four 16 KB pages starting at segment D000h
    localparam addr_t EMS_WINDOW_BASE = 20'hD0000;

    localparam int REFRESH_CYCLES = 4;

endpackage
